//--- logic/trace_pkg.sv
/*
  trace_pkg
  Shared types and constants for the instruction-trace path: field widths,
  the retirement and trace record structs, packet tags and the packetizer
  state encoding.
*/
package trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;     // one stream word
  typedef logic [4:0]  reg_addr_t; // integer register number
  typedef logic [1:0]  priv_t;     // privilege mode
  typedef logic [31:0] instr_t;    // raw instruction bits

  ////////////////////////////////////////////////////////////////////////////
  // records
  ////////////////////////////////////////////////////////////////////////////

  // pc and gpr_value are always 64 bits, upper half zero when XLEN is 32
  typedef struct packed {
    logic [63:0] pc;
    instr_t      instr;
    logic        trap;
    priv_t       priv;
    logic        gpr_wen;
    reg_addr_t   gpr_addr;
    logic [63:0] gpr_value;
  } retire_t;

  typedef struct packed {
    retire_t     ret;
    logic [31:0] minstret; // retirements since reset, first one is 1
  } trace_rec_t;

  // header tag in the upper half of word 0
  localparam logic [15:0] TRACE_MAGIC = 16'h7276;

  // first word of a received trigger frame
  localparam word_t TRIG_MAGIC = 32'h5452_4947;

  typedef enum logic [1:0] {
    INIT, // start-up wait
    IDLE,
    SEND,
    GAP   // spacing between packets
  } pkt_state_t;

endpackage

//--- logic/trace_capture.sv
/*
  trace_capture
  Registers each accepted retirement together with a running count of
  retired instructions and flags the new record for the packetizer.
*/
`timescale 1ns/1ps

module trace_capture #(
  parameter int XLEN = 64
) (
  input  logic                  cpu_clk,
  input  logic                  rst_n,
  input  logic                  retire_valid,
  input  trace_pkg::retire_t    retire,
  input  logic                  stall,
  output trace_pkg::trace_rec_t rec,
  output logic                  rec_valid
);

  // keeps only the architectural width of pc and register values
  localparam logic [63:0] XMASK = (XLEN == 64) ? {64{1'b1}} : 64'h0000_0000_ffff_ffff;

  logic        accept;
  logic [31:0] count_q;
  logic [31:0] count_next;

  assign accept     = retire_valid && !stall; // strobes under stall are dropped
  assign count_next = count_q + 32'd1;

  ////////////////////////////////////////////////////////////////////////////
  // retired-instruction counter and strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk) begin
    if (!rst_n) begin
      count_q   <= '0;
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= accept;
      if (accept) begin
        count_q <= count_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // record payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk) begin
    if (accept) begin
      rec.ret.pc        <= retire.pc & XMASK;
      rec.ret.instr     <= retire.instr;
      rec.ret.trap      <= retire.trap;
      rec.ret.priv      <= retire.priv;
      rec.ret.gpr_wen   <= retire.gpr_wen;
      rec.ret.gpr_addr  <= retire.gpr_addr;
      rec.ret.gpr_value <= retire.gpr_value & XMASK;
      rec.minstret      <= count_next; // count including this one
    end
  end

endmodule

//--- logic/trace_packetizer.sv
/*
  trace_packetizer
  Waits out a start-up timeout, then serializes each trace record onto a
  32-bit valid/ready/last stream. Holds the core in stall while a packet
  is in flight and during the gap that follows it.
*/
`timescale 1ns/1ps

module trace_packetizer #(
  parameter int XLEN         = 64,
  parameter int INIT_TIMEOUT = 100000000,
  parameter int PACKET_DELAY = 400
) (
  input  logic                  cpu_clk,
  input  logic                  rst_n,
  input  trace_pkg::trace_rec_t rec,
  input  logic                  rec_valid,
  input  logic                  tx_ready,
  output logic                  stall,
  output trace_pkg::word_t      tx_data,
  output logic                  tx_valid,
  output logic                  tx_last
);

  localparam int XWORDS = XLEN / 32;       // words per pc or register value
  localparam int NWORDS = 3 + 2 * XWORDS;  // header, pc, instr, minstret, gpr
  localparam int IDX_W  = $clog2(NWORDS);

  // word positions inside a packet
  localparam logic [IDX_W-1:0] PC_END       = IDX_W'(XWORDS);
  localparam logic [IDX_W-1:0] INSTR_IDX    = IDX_W'(XWORDS + 1);
  localparam logic [IDX_W-1:0] MINSTRET_IDX = IDX_W'(XWORDS + 2);
  localparam logic [IDX_W-1:0] LAST_IDX     = IDX_W'(NWORDS - 1);

  trace_pkg::pkt_state_t state_q;
  trace_pkg::trace_rec_t rec_q;
  logic [IDX_W-1:0]      idx_q;
  logic [31:0]           cnt_q;    // shared by start-up wait and gap
  logic [IDX_W-1:0]      pc_idx;
  logic [IDX_W-1:0]      gpr_idx;
  logic                  xfer;

  assign tx_valid = (state_q == trace_pkg::SEND);
  assign tx_last  = tx_valid && (idx_q == LAST_IDX);
  assign xfer     = tx_valid && tx_ready;
  assign stall    = (state_q != trace_pkg::IDLE) || rec_valid;

  ////////////////////////////////////////////////////////////////////////////
  // packet FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk) begin
    if (!rst_n) begin
      state_q <= trace_pkg::INIT;
      cnt_q   <= 32'(INIT_TIMEOUT - 1);
      idx_q   <= '0;
    end else begin
      case (state_q)
        trace_pkg::INIT: begin
          if (cnt_q == '0) state_q <= trace_pkg::IDLE;
          else cnt_q <= cnt_q - 32'd1;
        end
        trace_pkg::IDLE: begin
          if (rec_valid) begin
            state_q <= trace_pkg::SEND;
            idx_q   <= '0;
          end
        end
        trace_pkg::SEND: begin
          if (xfer) begin // advance only on a transfer
            if (tx_last) begin
              state_q <= trace_pkg::GAP;
              cnt_q   <= 32'(PACKET_DELAY - 1);
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        trace_pkg::GAP: begin
          if (cnt_q == '0) state_q <= trace_pkg::IDLE;
          else cnt_q <= cnt_q - 32'd1;
        end
        default: state_q <= trace_pkg::INIT;
      endcase
    end
  end

  // record held for the whole packet
  always_ff @(posedge cpu_clk) begin
    if (state_q == trace_pkg::IDLE && rec_valid) begin
      rec_q <= rec;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word select
  ////////////////////////////////////////////////////////////////////////////

  assign pc_idx  = idx_q - 1'b1;
  assign gpr_idx = idx_q - MINSTRET_IDX - 1'b1;

  always_comb begin
    if (idx_q == '0) begin
      tx_data = {trace_pkg::TRACE_MAGIC, rec_q.ret.priv, rec_q.ret.trap,
                 rec_q.ret.gpr_wen, rec_q.ret.gpr_addr, 7'b0};
    end else if (idx_q <= PC_END) begin
      tx_data = 32'(rec_q.ret.pc >> {pc_idx, 5'b0});        // low word first
    end else if (idx_q == INSTR_IDX) begin
      tx_data = rec_q.ret.instr;
    end else if (idx_q == MINSTRET_IDX) begin
      tx_data = rec_q.minstret;
    end else begin
      tx_data = 32'(rec_q.ret.gpr_value >> {gpr_idx, 5'b0});
    end
  end

endmodule

//--- logic/trigger_gen.sv
/*
  trigger_gen
  Watches the received word stream and pulses ila_trigger once after the
  last word of any frame whose first word is the trigger tag.
*/
`timescale 1ns/1ps

module trigger_gen (
  input  logic             cpu_clk,
  input  logic             rst_n,
  input  trace_pkg::word_t rx_data,
  input  logic             rx_valid,
  input  logic             rx_last,
  output logic             ila_trigger
);

  logic first_q; // next valid word opens a frame
  logic match_q; // first word of current frame was the tag
  logic hit;

  assign hit = first_q ? (rx_data == trace_pkg::TRIG_MAGIC) : match_q;

  ////////////////////////////////////////////////////////////////////////////
  // frame tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk) begin
    if (!rst_n) begin
      first_q <= 1'b1;
      match_q <= 1'b0;
    end else if (rx_valid) begin
      first_q <= rx_last;
      if (first_q) begin
        match_q <= (rx_data == trace_pkg::TRIG_MAGIC);
      end
    end
  end

  // one-cycle pulse after the closing word, one-word frames included
  always_ff @(posedge cpu_clk) begin
    if (!rst_n) begin
      ila_trigger <= 1'b0;
    end else begin
      ila_trigger <= rx_valid && rx_last && hit;
    end
  end

endmodule

//--- logic/trace_top.sv
/*
  trace_top
  Instruction-trace path: captures retirements, packetizes them onto a
  32-bit stream for the MAC and generates the trigger from received frames.
*/
`timescale 1ns/1ps

module trace_top #(
  parameter int XLEN         = 64,
  parameter int INIT_TIMEOUT = 100000000,
  parameter int PACKET_DELAY = 400
) (
  input  logic               cpu_clk,
  input  logic               rst_n,
  // retirement from the core
  input  logic               retire_valid,
  input  trace_pkg::retire_t retire,
  output logic               stall,
  // transmit stream to the MAC
  output trace_pkg::word_t   tx_data,
  output logic               tx_valid,
  output logic               tx_last,
  input  logic               tx_ready,
  // receive stream from the MAC
  input  trace_pkg::word_t   rx_data,
  input  logic               rx_valid,
  input  logic               rx_last,
  output logic               ila_trigger
);

  trace_pkg::trace_rec_t rec;
  logic                  rec_valid;

  trace_capture #(.XLEN(XLEN)) u_capture (
    .cpu_clk, .rst_n, .retire_valid, .retire, .stall,
    .rec, .rec_valid
  );

  trace_packetizer #(
    .XLEN         (XLEN),
    .INIT_TIMEOUT (INIT_TIMEOUT),
    .PACKET_DELAY (PACKET_DELAY)
  ) u_packetizer (
    .cpu_clk, .rst_n, .rec, .rec_valid, .tx_ready,
    .stall, .tx_data, .tx_valid, .tx_last
  );

  trigger_gen u_trigger (
    .cpu_clk, .rst_n, .rx_data, .rx_valid, .rx_last, .ila_trigger
  );

endmodule

//--- verif/trace_assertions.sv
/*
  trace_assertions
  Concurrent checks on the trace_top ports: reset state, start-up wait,
  stream hold under back-pressure, stall rules, packet gap and trigger frames.
*/
`timescale 1ns/1ps

module trace_assertions #(
  parameter int INIT_CYCLES = 20,
  parameter int MIN_GAP     = 4
) (
  input logic             cpu_clk,
  input logic             rst_n,
  input logic             retire_valid,
  input logic             stall,
  input trace_pkg::word_t tx_data,
  input logic             tx_valid,
  input logic             tx_last,
  input logic             tx_ready,
  input trace_pkg::word_t rx_data,
  input logic             rx_valid,
  input logic             rx_last,
  input logic             ila_trigger
);

  int unsigned      fail_count = 0;
  logic [31:0]      since_rst;  // cycles since reset release, saturating
  logic [31:0]      since_last; // cycles since last tx_last transfer, saturating
  logic             rx_open_q;  // an rx frame has started and not yet closed
  trace_pkg::word_t rx_head_q;  // first word of the open rx frame
  trace_pkg::word_t rx_head;    // first word of the frame of the current rx word

  assign rx_head = rx_open_q ? rx_head_q : rx_data;

  always_ff @(posedge cpu_clk) begin
    if (!rst_n) begin
      since_rst  <= 32'd0;
      since_last <= 32'(MIN_GAP); // no packet yet, first one is free
    end else begin
      if (since_rst < 32'(INIT_CYCLES)) since_rst <= since_rst + 32'd1;
      if (tx_valid && tx_ready && tx_last) since_last <= 32'd0;
      else if (since_last < 32'(MIN_GAP)) since_last <= since_last + 32'd1;
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (!rst_n) begin
      rx_open_q <= 1'b0;
    end else if (rx_valid) begin
      rx_open_q <= !rx_last;
      if (!rx_open_q) begin
        rx_head_q <= rx_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge cpu_clk)
    !rst_n |=> (stall && !tx_valid && !tx_last && !ila_trigger))
    else begin
      fail_count++;
      $error("outputs not in reset state");
    end

  a_init_wait: assert property (@(posedge cpu_clk) disable iff (!rst_n)
    since_rst < 32'(INIT_CYCLES) |-> (stall && !tx_valid))
    else begin
      fail_count++;
      $error("stall low or word sent during start-up wait");
    end

  a_hold: assert property (@(posedge cpu_clk) disable iff (!rst_n)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last)))
    else begin
      fail_count++;
      $error("stream word changed under back-pressure");
    end

  // stall may only drop once the packet and its gap are over
  a_stall_idle: assert property (@(posedge cpu_clk) disable iff (!rst_n)
    !stall |-> (!tx_valid && since_last >= 32'(MIN_GAP)))
    else begin
      fail_count++;
      $error("stall low while a packet or its gap is in progress");
    end

  a_strobe: assert property (@(posedge cpu_clk) disable iff (!rst_n)
    retire_valid |-> !stall)
    else begin
      fail_count++;
      $error("retirement strobe while stall is high");
    end

  a_gap: assert property (@(posedge cpu_clk) disable iff (!rst_n)
    $rose(tx_valid) |-> since_last >= 32'(MIN_GAP))
    else begin
      fail_count++;
      $error("packet started before the gap ended");
    end

  // pulse right after the closing word of a frame that opened with the tag
  a_trigger: assert property (@(posedge cpu_clk) disable iff (!rst_n)
    ila_trigger == $past(rx_valid && rx_last && (rx_head == trace_pkg::TRIG_MAGIC)))
    else begin
      fail_count++;
      $error("trigger does not follow the closing word of a tagged frame");
    end

endmodule

bind trace_top trace_assertions #(
  .INIT_CYCLES (INIT_TIMEOUT),
  .MIN_GAP     (PACKET_DELAY)
) u_checks (
  .cpu_clk, .rst_n, .retire_valid, .stall, .tx_data, .tx_valid,
  .tx_last, .tx_ready, .rx_data, .rx_valid, .rx_last, .ila_trigger
);

//--- verif/trace_tb.sv
/*
  trace_tb
  Testbench for the trace path. Sends random retirements under random
  back-pressure, checks every packet word, sends trigger frames and
  guards the run with a watchdog.
*/
`timescale 1ns/1ps

module trace_tb;

  localparam int XLEN            = 64;
  localparam int INIT_TIMEOUT    = 20;
  localparam int PACKET_DELAY    = 4;
  localparam int RST_CYCLES      = 10;
  localparam int NPKT            = 8;
  localparam int PKT_WORDS       = 3 + 2 * XLEN / 32;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + INIT_TIMEOUT + NPKT * 200 + 50; // 50 for rx frames
  localparam logic [31:0] SEED   = 32'h11940847;

  logic               cpu_clk = 1'b0;
  logic               rst_n;
  logic               retire_valid;
  trace_pkg::retire_t retire;
  logic               stall;
  trace_pkg::word_t   tx_data;
  logic               tx_valid;
  logic               tx_last;
  logic               tx_ready = 1'b0;
  trace_pkg::word_t   rx_data;
  logic               rx_valid;
  logic               rx_last;
  logic               ila_trigger;

  logic [31:0]      stim_seed  = SEED;
  logic [31:0]      ready_seed = {SEED[15:0], SEED[31:16]}; // separate stream for tx_ready
  trace_pkg::word_t exp_q[$];   // expected words of packets not yet sent
  trace_pkg::word_t exp_word;
  logic [31:0]      retired     = 32'd0;
  int               word_idx    = 0;
  int               pkt_idx     = 0;
  int               sb_errors   = 0;
  int               trig_errors = 0;
  int               trig_count  = 0;
  int               asrt_errors = 0;

  trace_top #(
    .XLEN         (XLEN),
    .INIT_TIMEOUT (INIT_TIMEOUT),
    .PACKET_DELAY (PACKET_DELAY)
  ) u_dut (
    .cpu_clk, .rst_n, .retire_valid, .retire, .stall,
    .tx_data, .tx_valid, .tx_last, .tx_ready,
    .rx_data, .rx_valid, .rx_last, .ila_trigger
  );

  always #50 cpu_clk = ~cpu_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ready high about three cycles in four
  always @(posedge cpu_clk) begin
    ready_seed = xorshift(ready_seed);
    tx_ready <= rst_n && (ready_seed[1:0] != 2'b00);
  end

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard and trigger counter
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge cpu_clk) begin
    if (rst_n && tx_valid && tx_ready) begin
      if (exp_q.size() == 0) begin
        $display("word 0x%08h was sent while no packet was pending", tx_data);
        sb_errors++;
      end else begin
        exp_word = exp_q.pop_front();
        if (tx_data !== exp_word) begin
          $display("FAILED packet_contents pkt %0d word %0d: expected 0x%08h, actual 0x%08h",
                   pkt_idx, word_idx, exp_word, tx_data);
          sb_errors++;
        end
        if (tx_last !== (word_idx == PKT_WORDS - 1)) begin
          $display("FAILED packet_last pkt %0d word %0d: expected %0b, actual %0b",
                   pkt_idx, word_idx, (word_idx == PKT_WORDS - 1), tx_last);
          sb_errors++;
        end
        if (word_idx == PKT_WORDS - 1) begin
          word_idx = 0;
          pkt_idx++;
        end else begin
          word_idx++;
        end
      end
    end
  end

  always @(posedge cpu_clk) begin
    if (rst_n && ila_trigger === 1'b1) trig_count++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // one random retirement, strobed only while stall is low
  task automatic retire_one();
    trace_pkg::retire_t r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    stim_seed = xorshift(stim_seed);
    a = stim_seed;
    stim_seed = xorshift(stim_seed);
    b = stim_seed;
    stim_seed = xorshift(stim_seed);
    c = stim_seed;
    stim_seed = xorshift(stim_seed);
    d = stim_seed;
    r.pc        = {b, a};
    r.instr     = c;
    r.trap      = d[0];
    r.priv      = d[2:1];
    r.gpr_wen   = d[3];
    r.gpr_addr  = d[8:4];
    r.gpr_value = {a ^ d, c ^ b};
    repeat (d[10:9]) @(posedge cpu_clk); // random idle time
    @(posedge cpu_clk);
    while (stall) @(posedge cpu_clk);
    retire       <= r;
    retire_valid <= 1'b1;
    retired = retired + 32'd1;
    exp_q.push_back({16'h7276, r.priv, r.trap, r.gpr_wen, r.gpr_addr, 7'b0});
    exp_q.push_back(r.pc[31:0]);
    exp_q.push_back(r.pc[63:32]);
    exp_q.push_back(r.instr);
    exp_q.push_back(retired);
    exp_q.push_back(r.gpr_value[31:0]);
    exp_q.push_back(r.gpr_value[63:32]);
    @(posedge cpu_clk);
    retire_valid <= 1'b0;
  endtask

  task automatic drive_rx_word(input trace_pkg::word_t d, input logic last);
    @(posedge cpu_clk);
    rx_data  <= d;
    rx_valid <= 1'b1;
    rx_last  <= last;
  endtask

  // trigger is due one cycle after the last word
  task automatic finish_frame(input string name, input logic expect_trig);
    @(posedge cpu_clk);
    rx_valid <= 1'b0;
    rx_last  <= 1'b0;
    @(posedge cpu_clk);
    if (ila_trigger !== expect_trig) begin
      $display("FAILED %s: expected %0b, actual %0b", name, expect_trig, ila_trigger);
      trig_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    retire_valid = 1'b0;
    retire       = '0;
    rx_data      = '0;
    rx_valid     = 1'b0;
    rx_last      = 1'b0;
    repeat (RST_CYCLES) @(posedge cpu_clk);
    rst_n <= 1'b1;
    repeat (NPKT) retire_one();
    while (exp_q.size() != 0) @(posedge cpu_clk);
    drive_rx_word(trace_pkg::TRIG_MAGIC, 1'b0);
    drive_rx_word(32'h0000_0001, 1'b0);
    drive_rx_word(32'h0000_0002, 1'b1);
    finish_frame("trigger_first_word", 1'b1);
    drive_rx_word(32'h0000_0000, 1'b0);
    drive_rx_word(trace_pkg::TRIG_MAGIC, 1'b0); // tag in a later word
    drive_rx_word(32'h0000_0003, 1'b1);
    finish_frame("trigger_later_word", 1'b0);
    drive_rx_word(trace_pkg::TRIG_MAGIC, 1'b1);
    finish_frame("trigger_single_word", 1'b1);
    repeat (4) @(posedge cpu_clk);
    if (trig_count != 2) begin
      $display("FAILED trigger_count: expected %0d, actual %0d", 2, trig_count);
      trig_errors++;
    end
    asrt_errors = u_dut.u_checks.fail_count;
    $display("errors: scoreboard %0d, trigger %0d, assertions %0d",
             sb_errors, trig_errors, asrt_errors);
    if (sb_errors + trig_errors + asrt_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

//--- trace.f
logic/trace_pkg.sv
logic/trace_capture.sv
logic/trace_packetizer.sv
logic/trigger_gen.sv
logic/trace_top.sv
verif/trace_assertions.sv
verif/trace_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the trace testbench with Verilator, result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f trace.f --top-module trace_tb -o trace_sim \
  > sim.log 2>&1 \
  && ./obj_dir/trace_sim +verilator+error+limit+1000 >> sim.log 2>&1
grep -q "tests failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL, no result in sim.log"; exit 1; }
echo "PASS"
